/* Bender.yml */
package:
  name: net_router

sources:
  - include_dirs:
      - .
    files:
      - net_msg_pkg.sv
      - net_ctrl_pkg.sv
      - net_queue.sv
      - net_route_ctrl.sv
      - net_crossbar.sv
      - net_router.sv
  - target: test
    include_dirs:
      - .
    files:
      - net_router_asserts.sv
      - tb_net_router.sv

/* compile.f */
+incdir+.
net_msg_pkg.sv
net_ctrl_pkg.sv
net_queue.sv
net_route_ctrl.sv
net_crossbar.sv
net_router.sv
net_router_asserts.sv
tb_net_router.sv

/* net_crossbar.sv */
/*
 * crossbar that drives each output with the head its arbiter granted
 */
`timescale 1ns/100ps
`default_nettype none

module net_crossbar
	import net_msg_pkg::*;
	import net_ctrl_pkg::*;
(
	input  logic      [num_queues-1:0] head_val,
	input  net_msg_t  [num_queues-1:0] head_msg,
	input  port_vec_t [num_ports-1:0]  grant,
	input  domain_t   [num_ports-1:0]  dom_sel,
	output port_vec_t                  out_val,
	output net_msg_t  [num_ports-1:0]  out_msg
);

	port_vec_t sel_val;

	// valid of the head each input put forward
	always_comb begin
		for (int p = 0; p < num_ports; p++)
			sel_val[p] = head_val[2*p + int'(dom_sel[p])];
	end

	// grants are one-hot so at most one input drives an output
	// an idle output shows zeros rather than a stale head
	always_comb begin
		for (int o = 0; o < num_ports; o++) begin
			out_val[o] = |(grant[o] & sel_val);
			out_msg[o] = '0;
			for (int i = 0; i < num_ports; i++) begin
				if (grant[o][i])
					out_msg[o] = head_msg[2*i + int'(dom_sel[i])];
			end
		end
	end

endmodule

`default_nettype wire

/* net_ctrl_pkg.sv */
/*
 * port naming and request/grant vectors of the router control
 */
`default_nettype none

package net_ctrl_pkg;

	// west, terminal and east make up the three router ports
	localparam int num_ports = 3;

	// every port keeps one queue for each of the two domains
	localparam int num_queues = 2 * num_ports;

	// east leads to the router with the next higher id
	typedef enum logic [1:0] {
		west = 2'd0,
		term = 2'd1,
		east = 2'd2
	} port_t;

	// one bit per port with bit positions given by port_t
	// used both for requests toward outputs and for grants to inputs
	typedef logic [num_ports-1:0] port_vec_t;

endpackage

`default_nettype wire

/* net_defs.svh */
/*
 * ring network sizes shared by the router sources
 * covers the ring length, the payload width and the queue depth
 */
`ifndef NET_DEFS_SVH
`define NET_DEFS_SVH

// number of routers on the ring with ids counting up from zero
`define NET_NUM_ROUTERS 8

// width of the data word that one message carries
`define NET_PAYLOAD_BITS 32

// entries in each per-domain input queue
`define NET_QUEUE_DEPTH 2

// destination and source fields must hold any router id
`define NET_DEST_BITS $clog2(`NET_NUM_ROUTERS)

`endif

/* net_msg_pkg.sv */
/*
 * message format of the ring network
 * one message is a single flit tagged with its traffic domain
 */
`default_nettype none

`include "net_defs.svh"

package net_msg_pkg;

	// two isolated traffic domains share every physical link
	typedef enum logic {
		d1 = 1'b0,
		d2 = 1'b1
	} domain_t;

	// router id as it appears in the destination and source fields
	typedef logic [`NET_DEST_BITS-1:0] dest_t;

	// the router only looks at dest and domain and passes the rest untouched
	typedef struct packed {
		dest_t                        dest;
		dest_t                        src;
		domain_t                      domain;
		logic [`NET_PAYLOAD_BITS-1:0] payload;
	} net_msg_t;

endpackage

`default_nettype wire

/* net_queue.sv */
/*
 * small circular FIFO with valid/ready on both sides
 * the payload type is a parameter so any message format fits
 */
`timescale 1ns/100ps
`default_nettype none

module net_queue #(
	parameter type payload_t = logic,
	parameter int  depth     = 2
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     enq_val,
	output logic     enq_rdy,
	input  payload_t enq_msg,
	output logic     deq_val,
	input  logic     deq_rdy,
	output payload_t deq_msg
);

	localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_bits = $clog2(depth + 1);

	payload_t            mem [depth];
	logic [ptr_bits-1:0] rd_ptr;
	logic [ptr_bits-1:0] wr_ptr;
	logic [cnt_bits-1:0] count;
	logic                do_enq;
	logic                do_deq;

	// a full queue refuses new data even when its head leaves this cycle
	assign enq_rdy = (count != cnt_bits'(depth));
	assign deq_val = (count != '0);
	assign deq_msg = mem[rd_ptr];

	assign do_enq = enq_val && enq_rdy;
	assign do_deq = deq_val && deq_rdy;

	// pointers wrap at depth so non power of two sizes work too
	function automatic logic [ptr_bits-1:0] bump(input logic [ptr_bits-1:0] ptr);
		return (ptr == ptr_bits'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (do_enq)
			mem[wr_ptr] <= enq_msg;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_enq)
				wr_ptr <= bump(wr_ptr);
			if (do_deq)
				rd_ptr <= bump(rd_ptr);
			// simultaneous push and pop leaves the count alone
			case ({do_enq, do_deq})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* net_route_ctrl.sv */
/*
 * router control that routes each queue head the short way round the ring
 * then picks a domain per input and arbitrates every output round-robin
 */
`timescale 1ns/100ps
`default_nettype none

`include "net_defs.svh"

module net_route_ctrl
	import net_msg_pkg::*;
	import net_ctrl_pkg::*;
#(
	parameter int router_id = 0
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic       [num_queues-1:0] head_val,
	input  dest_t      [num_queues-1:0] head_dest,
	input  port_vec_t                   out_rdy,
	output port_vec_t  [num_ports-1:0]  grant,
	output domain_t    [num_ports-1:0]  dom_sel,
	output logic       [num_queues-1:0] deq
);

	port_vec_t [num_queues-1:0] req_q;
	port_vec_t [num_ports-1:0]  req_in;
	port_vec_t [num_ports-1:0]  grant_new;
	port_vec_t [num_ports-1:0]  hold_grant;
	domain_t   [num_ports-1:0]  hold_dom;
	domain_t   [num_ports-1:0]  favour;
	port_t     [num_ports-1:0]  rr_ptr;
	port_vec_t                  held_in;
	port_vec_t                  taken_in;

	// ----------------------------------------
	// route computation
	// ----------------------------------------

	// hops are counted with east as the direction of rising ids
	// a tie between the two ways is sent east
	function automatic port_vec_t route(input dest_t dest);
		int        east_hops;
		int        west_hops;
		port_vec_t r;
		east_hops = (int'(dest) + `NET_NUM_ROUTERS - router_id) % `NET_NUM_ROUTERS;
		west_hops = (`NET_NUM_ROUTERS - east_hops) % `NET_NUM_ROUTERS;
		r = '0;
		if (east_hops == 0)
			r[term] = 1'b1;
		else if (east_hops <= west_hops)
			r[east] = 1'b1;
		else
			r[west] = 1'b1;
		return r;
	endfunction

	// the winner index moves one step on so the next search starts after it
	function automatic port_t next_port(input port_vec_t g);
		if (g[west])
			return term;
		else if (g[term])
			return east;
		return west;
	endfunction

	// queue q belongs to port q/2 and domain q%2
	always_comb begin
		for (int q = 0; q < num_queues; q++)
			req_q[q] = head_val[q] ? route(head_dest[q]) : '0;
	end

	// ----------------------------------------
	// domain choice per input
	// ----------------------------------------

	// an input whose grant is being held keeps the domain it had
	always_comb begin
		held_in = '0;
		for (int o = 0; o < num_ports; o++)
			held_in |= hold_grant[o];
	end

	always_comb begin
		for (int p = 0; p < num_ports; p++) begin
			if (held_in[p])
				dom_sel[p] = hold_dom[p];
			else if (head_val[2*p] && head_val[2*p+1])
				dom_sel[p] = favour[p];
			else if (head_val[2*p+1])
				dom_sel[p] = d2;
			else
				dom_sel[p] = d1;
			req_in[p] = req_q[2*p + int'(dom_sel[p])];
		end
	end

	// ----------------------------------------
	// output arbitration
	// ----------------------------------------

	// scanning from the far end lets the bidder nearest the pointer win
	always_comb begin
		int idx;
		taken_in = '0;
		for (int o = 0; o < num_ports; o++) begin
			grant_new[o] = '0;
			for (int k = num_ports - 1; k >= 0; k--) begin
				idx = (int'(rr_ptr[o]) + k) % num_ports;
				if (req_in[idx][o]) begin
					grant_new[o]      = '0;
					grant_new[o][idx] = 1'b1;
				end
			end
			// a stalled output stays with the input it already offered
			grant[o] = (hold_grant[o] != '0) ? hold_grant[o] : grant_new[o];
			if (out_rdy[o])
				taken_in |= grant[o];
		end
	end

	// only the chosen domain of a taken input pops its queue
	always_comb begin
		deq = '0;
		for (int p = 0; p < num_ports; p++)
			deq[2*p + int'(dom_sel[p])] = taken_in[p];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int o = 0; o < num_ports; o++) begin
				hold_grant[o] <= '0;
				rr_ptr[o]     <= west;
			end
			for (int p = 0; p < num_ports; p++) begin
				favour[p]   <= d1;
				hold_dom[p] <= d1;
			end
		end else begin
			for (int o = 0; o < num_ports; o++) begin
				hold_grant[o] <= out_rdy[o] ? '0 : grant[o];
				if (out_rdy[o] && grant[o] != '0)
					rr_ptr[o] <= next_port(grant[o]);
			end
			// the domain that did not leave gets the next tie
			for (int p = 0; p < num_ports; p++) begin
				hold_dom[p] <= dom_sel[p];
				if (taken_in[p])
					favour[p] <= (dom_sel[p] == d1) ? d2 : d1;
			end
		end
	end

endmodule

`default_nettype wire

/* net_router.sv */
/*
 * ring router with two traffic domains on three ports
 * six input queues feed the control and the crossbar
 */
`timescale 1ns/100ps
`default_nettype none

`include "net_defs.svh"

module net_router
	import net_msg_pkg::*;
	import net_ctrl_pkg::*;
#(
	parameter int router_id = 0
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  port_vec_t                  in_val,
	output port_vec_t                  in_rdy,
	input  net_msg_t  [num_ports-1:0]  in_msg,
	output port_vec_t                  out_val,
	input  port_vec_t                  out_rdy,
	output net_msg_t  [num_ports-1:0]  out_msg
);

	logic      [num_queues-1:0] enq_val;
	logic      [num_queues-1:0] enq_rdy;
	logic      [num_queues-1:0] head_val;
	net_msg_t  [num_queues-1:0] head_msg;
	dest_t     [num_queues-1:0] head_dest;
	logic      [num_queues-1:0] deq;
	port_vec_t [num_ports-1:0]  grant;
	domain_t   [num_ports-1:0]  dom_sel;

	// ----------------------------------------
	// input queues
	// ----------------------------------------

	// each offered message goes to the queue of its own domain
	for (genvar q = 0; q < num_queues; q++) begin : g_queue
		assign enq_val[q]   = in_val[q/2] && (in_msg[q/2].domain == domain_t'(q % 2));
		assign head_dest[q] = head_msg[q].dest;

		net_queue #(
			.payload_t (net_msg_t),
			.depth     (`NET_QUEUE_DEPTH)
		) u_queue (
			.clk     (clk),
			.rst_n   (rst_n),
			.enq_val (enq_val[q]),
			.enq_rdy (enq_rdy[q]),
			.enq_msg (in_msg[q/2]),
			.deq_val (head_val[q]),
			.deq_rdy (deq[q]),
			.deq_msg (head_msg[q])
		);
	end

	// readiness follows the queue that matches the offered domain
	for (genvar p = 0; p < num_ports; p++) begin : g_rdy
		assign in_rdy[p] = enq_rdy[2*p + int'(in_msg[p].domain)];
	end

	// ----------------------------------------
	// control and crossbar
	// ----------------------------------------

	net_route_ctrl #(
		.router_id (router_id)
	) u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.head_val  (head_val),
		.head_dest (head_dest),
		.out_rdy   (out_rdy),
		.grant     (grant),
		.dom_sel   (dom_sel),
		.deq       (deq)
	);

	net_crossbar u_xbar (
		.head_val (head_val),
		.head_msg (head_msg),
		.grant    (grant),
		.dom_sel  (dom_sel),
		.out_val  (out_val),
		.out_msg  (out_msg)
	);

endmodule

`default_nettype wire

/* net_router_asserts.sv */
/*
 * concurrent checks bound into the ring router
 * cover the reset state, back-pressure and the home port rule
 */
`timescale 1ns/100ps
`default_nettype none

module net_router_asserts
	import net_msg_pkg::*;
	import net_ctrl_pkg::*;
#(
	parameter int router_id = 0
) (
	input logic                      clk,
	input logic                      rst_n,
	input port_vec_t                 in_rdy,
	input port_vec_t                 out_val,
	input port_vec_t                 out_rdy,
	input net_msg_t  [num_ports-1:0] out_msg
);

	// number of failed checks in this instance
	int unsigned fail_count = 0;

	// a reset edge leaves every queue empty for the following cycle
	a_reset: assert property (@(posedge clk) !rst_n |=> out_val == '0 && in_rdy == '1)
	else begin
		$error("outputs active or inputs blocked right after reset");
		fail_count++;
	end

	for (genvar o = 0; o < num_ports; o++) begin : g_port
		// a stalled output keeps offering the same message
		a_hold: assert property (@(posedge clk) disable iff (!rst_n)
			out_val[o] && !out_rdy[o] |=> out_val[o] && $stable(out_msg[o]))
		else begin
			$error("port %0d dropped or changed its message while stalled", o);
			fail_count++;
		end

		// only the terminal port carries messages addressed to this router
		a_home: assert property (@(posedge clk) disable iff (!rst_n)
			out_val[o] |-> ((out_msg[o].dest == router_id) == (o == int'(term))))
		else begin
			$error("port %0d carries a message for the wrong side of the ring", o);
			fail_count++;
		end
	end

endmodule

// every router instance gets its own copy of the checks
bind net_router net_router_asserts #(
	.router_id (router_id)
) u_asserts (
	.clk     (clk),
	.rst_n   (rst_n),
	.in_rdy  (in_rdy),
	.out_val (out_val),
	.out_rdy (out_rdy),
	.out_msg (out_msg)
);

`default_nettype wire

/* tb_net_router.sv */
/*
 * testbench for the ring router under random traffic on all three ports
 * a scoreboard per input queue checks routing, order and delivery
 */
`timescale 1ns/100ps
`default_nettype none

`include "net_defs.svh"

module tb_net_router
	import net_msg_pkg::*;
	import net_ctrl_pkg::*;
();

	localparam int tb_router_id = 3;
	localparam int num_random   = 240;
	localparam int num_msgs     = num_random + 4;
	localparam int cycle_limit  = 20 * num_msgs;

	logic                     clk;
	logic                     rst_n;
	port_vec_t                in_val;
	port_vec_t                in_rdy;
	net_msg_t [num_ports-1:0] in_msg;
	port_vec_t                out_val;
	port_vec_t                out_rdy;
	net_msg_t [num_ports-1:0] out_msg;

	// expected lists indexed like the DUT queues, two per input port
	net_msg_t exp_q [num_queues][$];
	int       pending;
	int       seq;
	int       cycles;
	int       west_seen;
	logic     domain_phase;

	net_router #(
		.router_id (tb_router_id)
	) uut (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_val  (in_val),
		.in_rdy  (in_rdy),
		.in_msg  (in_msg),
		.out_val (out_val),
		.out_rdy (out_rdy),
		.out_msg (out_msg)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------
	// reference rules and helpers
	// ----------------------------------------

	// the shorter way round from this router wins and a message for home goes to the terminal
	function automatic port_t expected_port(input dest_t dest);
		int ahead;
		int behind;
		ahead  = (int'(dest) - tb_router_id + `NET_NUM_ROUTERS) % `NET_NUM_ROUTERS;
		behind = `NET_NUM_ROUTERS - ahead;
		if (ahead == 0)
			return term;
		else if (ahead <= behind)
			return east;
		else
			return west;
	endfunction

	// the top payload bits name the input port and the rest count messages
	function automatic net_msg_t make_msg(input int port, input domain_t dom, input int num);
		net_msg_t m;
		m.dest    = dest_t'($urandom % `NET_NUM_ROUTERS);
		m.src     = dest_t'($urandom);
		m.domain  = dom;
		m.payload = {2'(port), (`NET_PAYLOAD_BITS-2)'(num)};
		return m;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// match one message that left by output o against the list of its input queue
	task automatic check_departure(input int o, input net_msg_t m);
		int       src_port;
		int       q;
		net_msg_t exp;
		domain_t  want;
		src_port = int'(m.payload[`NET_PAYLOAD_BITS-1 -: 2]);
		q        = 2 * src_port + int'(m.domain);
		assert (src_port < num_ports && exp_q[q].size() != 0)
		else stop_run($sformatf("port %0d sent a message that was never accepted", o));
		exp = exp_q[q].pop_front();
		pending--;
		assert (m == exp)
		else stop_run($sformatf("mismatch out_msg[%0d]: got %h expected %h", o, m, exp));
		assert (port_t'(o) == expected_port(m.dest))
		else stop_run($sformatf("mismatch out_val port for dest %h: got %h expected %h",
			m.dest, port_t'(o), expected_port(m.dest)));
		// in the domain phase the west input must take turns between domains
		if (domain_phase && src_port == int'(west)) begin
			want = (west_seen % 2 == 0) ? d1 : d2;
			assert (m.domain == want)
			else stop_run($sformatf("mismatch out_msg.domain: got %h expected %h",
				m.domain, want));
			west_seen++;
		end
	endtask

	// offer one message and hold it until the DUT takes it
	task automatic send(input port_t p, input domain_t dom);
		in_val[p] <= 1'b1;
		in_msg[p] <= make_msg(int'(p), dom, seq);
		seq++;
		do
			@(posedge clk);
		while (!in_rdy[p]);
	endtask

	// the scoreboard is settled on the falling edge
	task automatic wait_drained();
		do
			@(negedge clk);
		while (pending != 0);
	endtask

	// ----------------------------------------
	// scoreboard and timeout
	// ----------------------------------------

	always @(posedge clk) begin
		if (rst_n) begin
			for (int p = 0; p < num_ports; p++) begin
				if (in_val[p] && in_rdy[p]) begin
					exp_q[2*p + int'(in_msg[p].domain)].push_back(in_msg[p]);
					pending++;
				end
			end
			for (int o = 0; o < num_ports; o++) begin
				if (out_val[o] && out_rdy[o])
					check_departure(o, out_msg[o]);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (uut.u_asserts.fail_count != 0)
			stop_run("a bound assertion in the router failed");
		else if (cycles >= cycle_limit)
			stop_run($sformatf("timeout, traffic did not drain within %0d cycles", cycle_limit));
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	initial begin
		int accepted;
		int offered;
		void'($urandom(32'h2908_5dfa));
		rst_n        = 1'b0;
		in_val       = '0;
		in_msg       = '0;
		out_rdy      = '0;
		pending      = 0;
		seq          = 0;
		cycles       = 0;
		west_seen    = 0;
		domain_phase = 1'b1;
		accepted     = 0;
		offered      = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// fill both west queues while stalled and then let them go with all outputs ready
		@(posedge clk);
		send(west, d1);
		send(west, d2);
		send(west, d1);
		send(west, d2);
		in_val[west] <= 1'b0;
		out_rdy      <= '1;
		wait_drained();
		domain_phase = 1'b0;

		// random traffic on every port with random back-pressure
		while (accepted < num_random) begin
			@(posedge clk);
			for (int p = 0; p < num_ports; p++) begin
				if (in_val[p] && in_rdy[p])
					accepted++;
				if (!in_val[p] || in_rdy[p]) begin
					if (offered < num_random && $urandom % 2 == 1) begin
						in_val[p] <= 1'b1;
						in_msg[p] <= make_msg(p, domain_t'($urandom % 2), seq);
						seq++;
						offered++;
					end else begin
						in_val[p] <= 1'b0;
					end
				end
			end
			for (int o = 0; o < num_ports; o++)
				out_rdy[o] <= ($urandom % 4) != 0;
		end

		out_rdy <= '1;
		wait_drained();
		repeat (2) @(negedge clk);
		assert (out_val == '0)
		else stop_run($sformatf("mismatch out_val after drain: got %h expected 0", out_val));
		assert (in_rdy == '1)
		else stop_run($sformatf("mismatch in_rdy after drain: got %h expected 7", in_rdy));

		if (uut.u_asserts.fail_count != 0)
			stop_run($sformatf("bound assertions failed %0d times", uut.u_asserts.fail_count));
		else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

`default_nettype wire
